/* logic/wbuf_pkg.sv */
// Write buffer shared definitions
package wbuf_pkg;

    // Fixed widths
    localparam int unsigned PA_WIDTH      = 32;
    localparam int unsigned WORD_WIDTH    = 64;
    localparam int unsigned TIMECNT_WIDTH = 3;

    // Upper bound on slot counts, set by the 8-bit data pointer
    localparam int unsigned MAX_ENTRIES = 256;

    typedef logic [PA_WIDTH-1:0]        wbuf_addr_t;
    typedef logic [WORD_WIDTH-1:0]      wbuf_word_t;
    typedef logic [WORD_WIDTH/8-1:0]    wbuf_be_t;
    typedef logic [TIMECNT_WIDTH-1:0]   wbuf_timecnt_t;
    typedef logic [MAX_ENTRIES-1:0]     wbuf_mask_t;

    typedef enum logic [1:0] {
        FREE   = 2'b00,
        OPEN   = 2'b01,
        CLOSED = 2'b10,
        SENT   = 2'b11
    } wbuf_state_e;

    // Directory command to the data store
    typedef struct packed {
        logic       alloc;
        logic       merge;
        logic [7:0] ptr;
    } wbuf_data_wr_t;

    // Round-robin search for the next candidate after curr
    // Returns curr when no other candidate exists
    function automatic int unsigned wbuf_find_next(
        input wbuf_mask_t  cand,
        input int unsigned curr,
        input int unsigned n
    );
        int unsigned idx;
        int unsigned result;
        logic        found;
        result = curr;
        found  = 1'b0;
        for (int unsigned i = 1; i <= n; i++) begin
            idx = (curr + i) % n;
            if (!found && cand[idx]) begin
                result = idx;
                found  = 1'b1;
            end
        end
        return result;
    endfunction

endpackage

/* logic/wbuf_fifo.sv */
// Registered send FIFO
`timescale 1ns/1ps

module wbuf_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     w_i,
    output logic     wok_o,
    input  payload_t wdata_i,
    input  logic     r_i,
    output logic     rok_o,
    output payload_t rdata_o
);
    localparam int unsigned PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_WIDTH = $clog2(DEPTH + 1);

    payload_t             mem_q [DEPTH];
    logic [PTR_WIDTH-1:0] wptr_q;
    logic [PTR_WIDTH-1:0] rptr_q;
    logic [CNT_WIDTH-1:0] count_q;
    logic                 do_w;
    logic                 do_r;

    assign wok_o   = (count_q != CNT_WIDTH'(DEPTH));
    assign rok_o   = (count_q != '0);
    assign do_w    = w_i & wok_o;
    assign do_r    = r_i & rok_o;
    assign rdata_o = mem_q[rptr_q];

    always_ff @(posedge clk_i) begin
        if (do_w) begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_w) begin
                wptr_q <= (wptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (do_r) begin
                rptr_q <= (rptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
            end
            case ({do_w, do_r})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // The writer must see wok_o before pushing
    no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_i |-> wok_o);

endmodule

/* logic/wbuf_directory.sv */
// Write buffer directory
`timescale 1ns/1ps

module wbuf_directory #(
    parameter int unsigned DIR_ENTRIES      = 4,
    parameter int unsigned DATA_ENTRIES     = 4,
    parameter int unsigned WORDS            = 4,
    parameter int unsigned READ_MATCH_WIDTH = 26,
    localparam int unsigned OFFSET_WIDTH    = $clog2(wbuf_pkg::WORD_WIDTH * WORDS / 8),
    localparam int unsigned TAG_WIDTH       = wbuf_pkg::PA_WIDTH - OFFSET_WIDTH,
    localparam int unsigned DIR_PTR_WIDTH   = $clog2(DIR_ENTRIES),
    localparam int unsigned DATA_PTR_WIDTH  = $clog2(DATA_ENTRIES)
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       close_all_i,
    input  wbuf_pkg::wbuf_timecnt_t    cfg_threshold_i,
    input  logic                       write_i,
    output logic                       write_ready_o,
    input  wbuf_pkg::wbuf_addr_t       write_addr_i,
    input  wbuf_pkg::wbuf_addr_t       read_addr_i,
    input  logic                       read_close_hit_i,
    output logic                       read_hit_o,
    input  logic                       data_free_i,
    input  logic [DATA_PTR_WIDTH-1:0]  data_free_ptr_i,
    output wbuf_pkg::wbuf_data_wr_t    data_wr_o,
    input  logic                       meta_wok_i,
    input  logic                       data_wok_i,
    output logic                       push_o,
    output logic [DIR_PTR_WIDTH-1:0]   push_id_o,
    output logic [TAG_WIDTH-1:0]       push_tag_o,
    output logic [DATA_PTR_WIDTH-1:0]  push_ptr_o,
    input  logic                       ack_i,
    input  logic [DIR_PTR_WIDTH-1:0]   ack_id_i,
    output logic                       empty_o,
    output logic                       full_o
);
    typedef logic [DIR_PTR_WIDTH-1:0] dir_ptr_t;
    typedef logic [TAG_WIDTH-1:0]     tag_t;

    typedef struct packed {
        logic [DATA_PTR_WIDTH-1:0] ptr;
        wbuf_pkg::wbuf_timecnt_t   cnt;
        tag_t                      tag;
    } dir_entry_t;

    wbuf_pkg::wbuf_state_e [DIR_ENTRIES-1:0] state_q, state_d;
    dir_entry_t [DIR_ENTRIES-1:0]            dir_q, dir_d;
    dir_ptr_t                                free_ptr_q, free_ptr_d;
    dir_ptr_t                                send_ptr_q, send_ptr_d;
    dir_ptr_t                                hit_ptr;
    tag_t                                    write_tag;
    logic                                    hit;
    logic                                    new_ok;
    logic                                    alloc;
    logic [DIR_ENTRIES-1:0]                  read_match;
    wbuf_pkg::wbuf_mask_t                    free_mask;
    wbuf_pkg::wbuf_mask_t                    closed_mask;

    assign write_tag = write_addr_i[wbuf_pkg::PA_WIDTH-1:OFFSET_WIDTH];

    // Tag lookup, read match and state masks
    always_comb begin
        hit         = 1'b0;
        hit_ptr     = '0;
        free_mask   = '0;
        closed_mask = '0;
        for (int unsigned i = 0; i < DIR_ENTRIES; i++) begin
            if ((state_q[i] == wbuf_pkg::OPEN || state_q[i] == wbuf_pkg::CLOSED) &&
                dir_q[i].tag == write_tag) begin
                hit     = 1'b1;
                hit_ptr = dir_ptr_t'(i);
            end
            read_match[i] = (state_q[i] != wbuf_pkg::FREE) &&
                (dir_q[i].tag[TAG_WIDTH-1 -: READ_MATCH_WIDTH] ==
                 read_addr_i[wbuf_pkg::PA_WIDTH-1 -: READ_MATCH_WIDTH]);
            free_mask[i]   = (state_q[i] == wbuf_pkg::FREE);
            closed_mask[i] = (state_q[i] == wbuf_pkg::CLOSED);
        end
    end

    assign read_hit_o = |read_match;
    assign empty_o    = &free_mask[DIR_ENTRIES-1:0];
    assign full_o     = ~|free_mask[DIR_ENTRIES-1:0];

    // New lines need a free slot in both directory and data store
    assign new_ok        = (state_q[free_ptr_q] == wbuf_pkg::FREE) & data_free_i & ~hit;
    assign write_ready_o = new_ok | hit;
    assign alloc         = write_i & new_ok;

    always_comb begin
        data_wr_o.alloc = alloc;
        data_wr_o.merge = write_i & hit;
        data_wr_o.ptr   = '0;
        data_wr_o.ptr[DATA_PTR_WIDTH-1:0] = alloc ? data_free_ptr_i : dir_q[hit_ptr].ptr;
    end

    assign push_o     = (state_q[send_ptr_q] == wbuf_pkg::CLOSED) & meta_wok_i & data_wok_i;
    assign push_id_o  = send_ptr_q;
    assign push_tag_o = dir_q[send_ptr_q].tag;
    assign push_ptr_o = dir_q[send_ptr_q].ptr;

    // Slot FSMs
    always_comb begin
        state_d = state_q;
        dir_d   = dir_q;
        for (int unsigned i = 0; i < DIR_ENTRIES; i++) begin
            case (state_q[i])
                wbuf_pkg::FREE: begin
                    if (alloc && i == int'(free_ptr_q)) begin
                        state_d[i] = (cfg_threshold_i == '0 || close_all_i) ?
                            wbuf_pkg::CLOSED : wbuf_pkg::OPEN;
                        dir_d[i].tag = write_tag;
                        dir_d[i].cnt = '0;
                        dir_d[i].ptr = data_free_ptr_i;
                    end
                end
                wbuf_pkg::OPEN: begin
                    if (close_all_i || (read_close_hit_i && read_match[i]) ||
                        dir_q[i].cnt == cfg_threshold_i - 1'b1) begin
                        state_d[i] = wbuf_pkg::CLOSED;
                    end else begin
                        dir_d[i].cnt = dir_q[i].cnt + 1'b1;
                    end
                end
                wbuf_pkg::CLOSED: begin
                    if (push_o && i == int'(send_ptr_q)) begin
                        state_d[i] = wbuf_pkg::SENT;
                    end
                end
                default: begin
                    if (ack_i && i == int'(ack_id_i)) begin
                        state_d[i] = wbuf_pkg::FREE;
                    end
                end
            endcase
        end
    end

    // Free pointer jumps to a released slot, send pointer waits on its push
    always_comb begin
        free_ptr_d = free_ptr_q;
        if (ack_i) begin
            free_ptr_d = ack_id_i;
        end else if (alloc) begin
            free_ptr_d = dir_ptr_t'(wbuf_pkg::wbuf_find_next(free_mask, free_ptr_q, DIR_ENTRIES));
        end
        send_ptr_d = dir_ptr_t'(wbuf_pkg::wbuf_find_next(closed_mask, send_ptr_q, DIR_ENTRIES));
        if (state_q[send_ptr_q] == wbuf_pkg::CLOSED && !push_o) begin
            send_ptr_d = send_ptr_q;
        end
    end

    always_ff @(posedge clk_i) begin
        dir_q <= dir_d;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= {DIR_ENTRIES{wbuf_pkg::FREE}};
            free_ptr_q <= '0;
            send_ptr_q <= '0;
        end else begin
            state_q    <= state_d;
            free_ptr_q <= free_ptr_d;
            send_ptr_q <= send_ptr_d;
        end
    end

    // Memory acknowledges only lines it was sent
    ack_of_sent: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |-> state_q[ack_id_i] == wbuf_pkg::SENT);

endmodule

/* logic/wbuf_data_store.sv */
// Write buffer line data store
`timescale 1ns/1ps

module wbuf_data_store #(
    parameter int unsigned DATA_ENTRIES = 4,
    parameter int unsigned WORDS        = 4,
    localparam int unsigned PTR_WIDTH   = $clog2(DATA_ENTRIES)
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  wbuf_pkg::wbuf_data_wr_t           data_wr_i,
    input  wbuf_pkg::wbuf_addr_t              write_addr_i,
    input  wbuf_pkg::wbuf_word_t              write_data_i,
    input  wbuf_pkg::wbuf_be_t                write_be_i,
    input  logic [PTR_WIDTH-1:0]              rd_ptr_i,
    input  logic                              release_i,
    output logic                              data_free_o,
    output logic [PTR_WIDTH-1:0]              data_free_ptr_o,
    output wbuf_pkg::wbuf_word_t [WORDS-1:0]  line_data_o,
    output wbuf_pkg::wbuf_be_t [WORDS-1:0]    line_be_o
);
    localparam int unsigned BYTES       = wbuf_pkg::WORD_WIDTH / 8;
    localparam int unsigned WORD_OFFSET = $clog2(BYTES);

    typedef struct packed {
        wbuf_pkg::wbuf_word_t [WORDS-1:0] data;
        wbuf_pkg::wbuf_be_t [WORDS-1:0]   be;
    } line_t;

    line_t                  line_q [DATA_ENTRIES];
    line_t                  old_line;
    line_t                  new_line;
    logic [DATA_ENTRIES-1:0] valid_q, valid_d;
    logic [PTR_WIDTH-1:0]   free_ptr_q, free_ptr_d;
    logic [PTR_WIDTH-1:0]   wr_ptr;
    int unsigned            word_sel;
    wbuf_pkg::wbuf_mask_t   free_mask;

    assign wr_ptr   = data_wr_i.ptr[PTR_WIDTH-1:0];
    assign word_sel = int'(write_addr_i >> WORD_OFFSET) % WORDS;

    // Byte merge into the selected word, a fresh line starts from zero
    always_comb begin
        old_line = data_wr_i.alloc ? '0 : line_q[wr_ptr];
        new_line = old_line;
        for (int unsigned w = 0; w < WORDS; w++) begin
            if (w == word_sel) begin
                for (int unsigned b = 0; b < BYTES; b++) begin
                    if (write_be_i[b]) begin
                        new_line.data[w][b*8 +: 8] = write_data_i[b*8 +: 8];
                    end
                end
                new_line.be[w] = old_line.be[w] | write_be_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_wr_i.alloc || data_wr_i.merge) begin
            line_q[wr_ptr] <= new_line;
        end
    end

    always_comb begin
        free_mask = '0;
        free_mask[DATA_ENTRIES-1:0] = ~valid_q;
        valid_d    = valid_q;
        free_ptr_d = free_ptr_q;
        if (data_wr_i.alloc) begin
            valid_d[wr_ptr] = 1'b1;
            free_ptr_d = PTR_WIDTH'(wbuf_pkg::wbuf_find_next(free_mask, free_ptr_q,
                                                             DATA_ENTRIES));
        end
        if (release_i) begin
            valid_d[rd_ptr_i] = 1'b0;
            free_ptr_d = rd_ptr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            free_ptr_q <= '0;
        end else begin
            valid_q    <= valid_d;
            free_ptr_q <= free_ptr_d;
        end
    end

    assign data_free_o     = ~valid_q[free_ptr_q];
    assign data_free_ptr_o = free_ptr_q;
    assign line_data_o     = line_q[rd_ptr_i].data;
    assign line_be_o       = line_q[rd_ptr_i].be;

    // The directory allocates only slots offered as free
    alloc_into_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_wr_i.alloc |-> !valid_q[wr_ptr]);
    // Data FIFO head must point at a held line
    release_of_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        release_i |-> valid_q[rd_ptr_i]);

endmodule

/* logic/wbuf_top.sv */
// Write buffer top level
`timescale 1ns/1ps

module wbuf_top #(
    parameter int unsigned DIR_ENTRIES      = 4,
    parameter int unsigned DATA_ENTRIES     = 4,
    parameter int unsigned WORDS            = 4,
    parameter int unsigned READ_MATCH_WIDTH = 26,
    localparam int unsigned OFFSET_WIDTH    = $clog2(wbuf_pkg::WORD_WIDTH * WORDS / 8),
    localparam int unsigned TAG_WIDTH       = wbuf_pkg::PA_WIDTH - OFFSET_WIDTH,
    localparam int unsigned DIR_PTR_WIDTH   = $clog2(DIR_ENTRIES),
    localparam int unsigned DATA_PTR_WIDTH  = $clog2(DATA_ENTRIES)
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    output logic                              empty_o,
    output logic                              full_o,
    input  logic                              close_all_i,
    input  wbuf_pkg::wbuf_timecnt_t           cfg_threshold_i,
    input  logic                              write_i,
    output logic                              write_ready_o,
    input  wbuf_pkg::wbuf_addr_t              write_addr_i,
    input  wbuf_pkg::wbuf_word_t              write_data_i,
    input  wbuf_pkg::wbuf_be_t                write_be_i,
    input  wbuf_pkg::wbuf_addr_t              read_addr_i,
    output logic                              read_hit_o,
    input  logic                              read_close_hit_i,
    input  logic                              send_meta_ready_i,
    output logic                              send_meta_valid_o,
    output wbuf_pkg::wbuf_addr_t              send_addr_o,
    output logic [DIR_PTR_WIDTH-1:0]          send_id_o,
    input  logic                              send_data_ready_i,
    output logic                              send_data_valid_o,
    output wbuf_pkg::wbuf_addr_t              send_data_tag_o,
    output wbuf_pkg::wbuf_word_t [WORDS-1:0]  send_data_o,
    output wbuf_pkg::wbuf_be_t [WORDS-1:0]    send_be_o,
    input  logic                              ack_i,
    input  logic [DIR_PTR_WIDTH-1:0]          ack_id_i
);
    typedef struct packed {
        logic [TAG_WIDTH-1:0]     tag;
        logic [DIR_PTR_WIDTH-1:0] id;
    } send_meta_t;

    typedef struct packed {
        logic [DATA_PTR_WIDTH-1:0] ptr;
        logic [TAG_WIDTH-1:0]      tag;
    } send_data_t;

    wbuf_pkg::wbuf_data_wr_t   data_wr;
    logic                      data_free;
    logic [DATA_PTR_WIDTH-1:0] data_free_ptr;
    logic                      push;
    logic [DIR_PTR_WIDTH-1:0]  push_id;
    logic [TAG_WIDTH-1:0]      push_tag;
    logic [DATA_PTR_WIDTH-1:0] push_ptr;
    logic                      meta_wok;
    logic                      data_wok;
    logic                      data_release;
    send_meta_t                meta_head;
    send_data_t                data_head;

    wbuf_directory #(
        .DIR_ENTRIES      (DIR_ENTRIES),
        .DATA_ENTRIES     (DATA_ENTRIES),
        .WORDS            (WORDS),
        .READ_MATCH_WIDTH (READ_MATCH_WIDTH)
    ) u_directory (
        .clk_i, .rst_ni, .close_all_i, .cfg_threshold_i,
        .write_i, .write_ready_o, .write_addr_i,
        .read_addr_i, .read_close_hit_i, .read_hit_o,
        .data_free_i     (data_free),
        .data_free_ptr_i (data_free_ptr),
        .data_wr_o       (data_wr),
        .meta_wok_i      (meta_wok),
        .data_wok_i      (data_wok),
        .push_o          (push),
        .push_id_o       (push_id),
        .push_tag_o      (push_tag),
        .push_ptr_o      (push_ptr),
        .ack_i, .ack_id_i, .empty_o, .full_o
    );

    wbuf_data_store #(
        .DATA_ENTRIES (DATA_ENTRIES),
        .WORDS        (WORDS)
    ) u_data_store (
        .clk_i, .rst_ni,
        .data_wr_i       (data_wr),
        .write_addr_i, .write_data_i, .write_be_i,
        .rd_ptr_i        (data_head.ptr),
        .release_i       (data_release),
        .data_free_o     (data_free),
        .data_free_ptr_o (data_free_ptr),
        .line_data_o     (send_data_o),
        .line_be_o       (send_be_o)
    );

    wbuf_fifo #(
        .DEPTH     (DATA_ENTRIES),
        .payload_t (send_meta_t)
    ) u_meta_fifo (
        .clk_i, .rst_ni,
        .w_i     (push),
        .wok_o   (meta_wok),
        .wdata_i ('{tag: push_tag, id: push_id}),
        .r_i     (send_meta_ready_i),
        .rok_o   (send_meta_valid_o),
        .rdata_o (meta_head)
    );

    wbuf_fifo #(
        .DEPTH     (DATA_ENTRIES),
        .payload_t (send_data_t)
    ) u_data_fifo (
        .clk_i, .rst_ni,
        .w_i     (push),
        .wok_o   (data_wok),
        .wdata_i ('{ptr: push_ptr, tag: push_tag}),
        .r_i     (send_data_ready_i),
        .rok_o   (send_data_valid_o),
        .rdata_o (data_head)
    );

    // Data slot is released on the data-channel transfer
    assign data_release    = send_data_valid_o & send_data_ready_i;
    assign send_addr_o     = {meta_head.tag, {OFFSET_WIDTH{1'b0}}};
    assign send_id_o       = meta_head.id;
    assign send_data_tag_o = {data_head.tag, {OFFSET_WIDTH{1'b0}}};

endmodule

/* verification/wbuf_tb_tasks.svh */
// Write buffer testbench tasks
`ifndef WBUF_TB_TASKS_SVH
`define WBUF_TB_TASKS_SVH

function automatic logic [63:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
endfunction

// Scoreboard slot holding the line of addr, or -1
function automatic int sb_find(input logic [31:0] addr);
    int idx;
    idx = -1;
    for (int i = 0; i < SB_SIZE; i++) begin
        if (sb_used[i] && sb_tag[i] == (addr & ~32'h1f)) begin
            idx = i;
        end
    end
    return idx;
endfunction

function automatic logic [255:0] sb_line_data(input logic [31:0] addr);
    int idx;
    idx = sb_find(addr);
    return (idx < 0) ? '0 : sb_data[idx];
endfunction

function automatic logic [31:0] sb_line_be(input logic [31:0] addr);
    int idx;
    idx = sb_find(addr);
    return (idx < 0) ? '0 : sb_be[idx];
endfunction

task automatic sb_write(input logic [31:0] addr, input logic [63:0] data,
                        input logic [7:0] be);
    int idx;
    int lane;
    idx = sb_find(addr);
    lane = int'(addr[4:3]);
    for (int i = SB_SIZE - 1; i >= 0 && idx < 0; i--) begin
        if (!sb_used[i]) begin
            idx = i;
        end
    end
    if (!sb_used[idx]) begin
        sb_used[idx] = 1'b1;
        sb_tag[idx]  = addr & ~32'h1f;
        sb_data[idx] = '0;
        sb_be[idx]   = '0;
    end
    for (int b = 0; b < 8; b++) begin
        if (be[b]) begin
            sb_data[idx][lane*64 + b*8 +: 8] = data[b*8 +: 8];
            sb_be[idx][lane*8 + b] = 1'b1;
        end
    end
endtask

task automatic expect_value(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    assert (got == exp) else begin
        errors++;
        $display("** Error %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
endtask

// Called at a rising edge, returns at the edge that accepts the write
task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] be);
    logic ok;
    ok = 1'b0;
    write_i      <= 1'b1;
    write_addr_i <= addr;
    write_data_i <= data;
    write_be_i   <= be;
    for (int t = 0; t < TIMEOUT && !ok; t++) begin
        @(negedge clk_i);
        ok = write_ready_o;
        @(posedge clk_i);
    end
    if (ok) begin
        sb_write(addr, data, be);
    end else begin
        errors++;
        $display("Write to 0x%0h was never accepted", addr);
    end
endtask

task automatic write_stop();
    write_i <= 1'b0;
endtask

// Expects metadata sooner than a timer at threshold 7 could close the line
task automatic wait_meta_valid(input int limit, input string what);
    logic seen;
    seen = 1'b0;
    for (int t = 0; t < limit && !seen; t++) begin
        @(negedge clk_i);
        seen = send_meta_valid_o;
        @(posedge clk_i);
    end
    if (!seen) begin
        errors++;
        $display("No send within %0d cycles after %s", limit, what);
    end
endtask

// Takes n transfers from each send channel, recording ids and addresses
task automatic drain_sends(input int n);
    int meta_n;
    int data_n;
    meta_n = 0;
    data_n = 0;
    send_meta_ready_i <= 1'b1;
    send_data_ready_i <= 1'b1;
    for (int t = 0; t < TIMEOUT && (meta_n < n || data_n < n); t++) begin
        @(negedge clk_i);
        if (send_meta_valid_o && send_meta_ready_i) begin
            got_ids.push_back(int'(send_id_o));
            got_tags.push_back(send_addr_o);
            meta_n++;
        end
        if (send_data_valid_o && send_data_ready_i) begin
            data_n++;
        end
        @(posedge clk_i);
        if (meta_n >= n) send_meta_ready_i <= 1'b0;
        if (data_n >= n) send_data_ready_i <= 1'b0;
    end
    if (meta_n < n || data_n < n) begin
        errors++;
        $display("Timed out waiting for sends: %0d meta and %0d data of %0d",
                 meta_n, data_n, n);
    end
endtask

// Acknowledges every recorded id, then checks the buffer is empty
task automatic ack_sent();
    while (got_ids.size() > 0) begin
        ack_i    <= 1'b1;
        ack_id_i <= 2'(got_ids.pop_front());
        @(posedge clk_i);
    end
    ack_i <= 1'b0;
    got_tags.delete();
    for (int i = 0; i < SB_SIZE; i++) begin
        sb_used[i] = 1'b0;
    end
    @(negedge clk_i);
    expect_value("empty_o", empty_o, 1);
    @(posedge clk_i);
endtask

`endif

/* verification/wbuf_tb.sv */
// Write buffer testbench
`timescale 1ns/1ps

module wbuf_tb;
    localparam int DIR_ENTRIES = 4;
    localparam int SB_SIZE     = 8;
    localparam int TIMEOUT     = 200;

    logic                             clk_i;
    logic                             rst_ni;
    logic                             close_all_i;
    wbuf_pkg::wbuf_timecnt_t          cfg_threshold_i;
    logic                             write_i;
    logic [31:0]                      write_addr_i;
    logic [63:0]                      write_data_i;
    logic [7:0]                       write_be_i;
    logic [31:0]                      read_addr_i;
    logic                             read_close_hit_i;
    logic                             send_meta_ready_i;
    logic                             send_data_ready_i;
    logic                             ack_i;
    logic [1:0]                       ack_id_i;
    logic                             empty_o;
    logic                             full_o;
    logic                             write_ready_o;
    logic                             read_hit_o;
    logic                             send_meta_valid_o;
    logic [31:0]                      send_addr_o;
    logic [1:0]                       send_id_o;
    logic                             send_data_valid_o;
    logic [31:0]                      send_data_tag_o;
    wbuf_pkg::wbuf_word_t [3:0]       send_data_o;
    wbuf_pkg::wbuf_be_t [3:0]         send_be_o;

    // Expected lines keyed by line address
    logic                             sb_used [SB_SIZE];
    logic [31:0]                      sb_tag [SB_SIZE];
    logic [255:0]                     sb_data [SB_SIZE];
    logic [31:0]                      sb_be [SB_SIZE];
    int                               got_ids [$];
    logic [31:0]                      got_tags [$];
    logic [63:0]                      rng_state;
    int                               errors;
    int                               tests_passed;
    int                               tests_failed;
    int                               mark;
    logic [63:0]                      word;

    `include "wbuf_tb_tasks.svh"

    wbuf_top #(
        .DIR_ENTRIES (DIR_ENTRIES)
    ) UUT (
        .clk_i, .rst_ni, .empty_o, .full_o, .close_all_i, .cfg_threshold_i,
        .write_i, .write_ready_o, .write_addr_i, .write_data_i, .write_be_i,
        .read_addr_i, .read_hit_o, .read_close_hit_i,
        .send_meta_ready_i, .send_meta_valid_o, .send_addr_o, .send_id_o,
        .send_data_ready_i, .send_data_valid_o, .send_data_tag_o,
        .send_data_o, .send_be_o, .ack_i, .ack_id_i
    );

    // Send channel checks against the scoreboard
    data_matches: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (send_data_valid_o && send_data_ready_i) |->
            send_data_o == sb_line_data(send_data_tag_o))
        else begin
            errors++;
            $display("** Error send_data_o: got 0x%0h expected 0x%0h",
                     send_data_o, sb_line_data(send_data_tag_o));
        end
    be_matches: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (send_data_valid_o && send_data_ready_i) |->
            send_be_o == sb_line_be(send_data_tag_o))
        else begin
            errors++;
            $display("** Error send_be_o: got 0x%0h expected 0x%0h",
                     send_be_o, sb_line_be(send_data_tag_o));
        end
    data_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (send_data_valid_o && send_data_ready_i) |->
            (sb_find(send_data_tag_o) >= 0 && send_data_tag_o[4:0] == 5'h0))
        else begin
            errors++;
            $display("Data for line 0x%0h was sent but never written", send_data_tag_o);
        end
    meta_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (send_meta_valid_o && send_meta_ready_i) |->
            (sb_find(send_addr_o) >= 0 && send_addr_o[4:0] == 5'h0))
        else begin
            errors++;
            $display("Line 0x%0h was sent but never written", send_addr_o);
        end

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic report_test(input string name);
        if (errors == mark) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed", name);
        end
        mark = errors;
    endtask

    initial begin
        rst_ni            = 1'b0;
        close_all_i       = 1'b0;
        cfg_threshold_i   = 3'd7;
        write_i           = 1'b0;
        write_addr_i      = '0;
        write_data_i      = '0;
        write_be_i        = '0;
        read_addr_i       = '0;
        read_close_hit_i  = 1'b0;
        send_meta_ready_i = 1'b0;
        send_data_ready_i = 1'b0;
        ack_i             = 1'b0;
        ack_id_i          = '0;
        rng_state         = 64'd97;
        errors            = 0;
        mark              = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        for (int i = 0; i < SB_SIZE; i++) begin
            sb_used[i] = 1'b0;
        end
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        @(negedge clk_i);
        expect_value("empty_o", empty_o, 1);
        expect_value("full_o", full_o, 0);
        expect_value("send_meta_valid_o", send_meta_valid_o, 0);
        expect_value("send_data_valid_o", send_data_valid_o, 0);
        report_test("reset state");

        @(posedge clk_i);
        write_word(32'h0000_1218, next_rand(), 8'hff);
        write_stop();
        close_all_i <= 1'b1;
        @(posedge clk_i);
        close_all_i <= 1'b0;
        drain_sends(1);
        ack_sent();
        report_test("close-all send");

        // Overlapping bytes in word 1, plus word 3
        word = next_rand();
        write_word(32'h0000_2448, word, 8'h0f);
        write_word(32'h0000_2448, next_rand(), 8'h3c);
        write_word(32'h0000_2458, next_rand(), 8'hf0);
        write_word(32'h0000_244c, next_rand(), 8'h81);
        write_stop();
        close_all_i <= 1'b1;
        @(posedge clk_i);
        close_all_i <= 1'b0;
        drain_sends(1);
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        expect_value("send_meta_valid_o", send_meta_valid_o, 0);
        @(posedge clk_i);
        ack_sent();
        report_test("merge");

        cfg_threshold_i <= 3'd3;
        write_word(32'h0000_3000, next_rand(), 8'h55);
        write_stop();
        drain_sends(1);
        ack_sent();
        cfg_threshold_i <= 3'd0;
        write_word(32'h0000_3460, next_rand(), 8'haa);
        write_stop();
        wait_meta_valid(4, "a write at threshold 0");
        drain_sends(1);
        ack_sent();
        cfg_threshold_i <= 3'd7;
        report_test("timer");

        write_word(32'h0000_4008, next_rand(), 8'hff);
        write_stop();
        read_addr_i <= 32'h0000_4020;
        @(negedge clk_i);
        expect_value("read_hit_o", read_hit_o, 1);
        @(posedge clk_i);
        read_addr_i <= 32'h0000_8000;
        @(negedge clk_i);
        expect_value("read_hit_o", read_hit_o, 0);
        @(posedge clk_i);
        read_addr_i      <= 32'h0000_4000;
        read_close_hit_i <= 1'b1;
        @(posedge clk_i);
        read_close_hit_i <= 1'b0;
        wait_meta_valid(4, "a read close hit");
        drain_sends(1);
        ack_sent();
        @(negedge clk_i);
        expect_value("read_hit_o", read_hit_o, 0);
        @(posedge clk_i);
        report_test("read hit and close");

        for (int i = 0; i < DIR_ENTRIES; i++) begin
            write_word(32'h0001_0000 + 32'(i) * 32'h40, next_rand(), 8'hff);
        end
        write_stop();
        write_addr_i <= 32'h0002_0000;
        @(negedge clk_i);
        for (int t = 0; t < TIMEOUT && !full_o; t++) begin
            @(negedge clk_i);
        end
        expect_value("full_o", full_o, 1);
        expect_value("write_ready_o", write_ready_o, 0);
        @(posedge clk_i);
        drain_sends(DIR_ENTRIES);
        expect_value("send count", got_ids.size(), DIR_ENTRIES);
        for (int i = 0; i < got_ids.size(); i++) begin
            for (int j = i + 1; j < got_ids.size(); j++) begin
                assert (got_ids[i] != got_ids[j]) else begin
                    errors++;
                    $display("Id %0d was sent twice", got_ids[i]);
                end
                assert (got_tags[i] != got_tags[j]) else begin
                    errors++;
                    $display("Line 0x%0h was sent twice", got_tags[i]);
                end
            end
        end
        ack_sent();
        report_test("back-pressure");

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* wbuf.f */
+incdir+verification
logic/wbuf_pkg.sv
logic/wbuf_fifo.sv
logic/wbuf_directory.sv
logic/wbuf_data_store.sv
logic/wbuf_top.sv
verification/wbuf_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the write buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f wbuf.f --top-module wbuf_tb -o wbuf_sim

./obj_dir/wbuf_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    exit 1
fi
grep -q '\*\* PASS \*\*' sim.log
exit 0
